// ==== all.f ====
hw/jtag_pkg.sv
hw/jtag_tap.sv
hw/jtag_dtm.sv
hw/jtag_dm_regs.sv
hw/jtag_debug_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== hw/jtag_debug_top.sv ====
// ##########################################################
// jtag debug top: TAP, DTM and debug register file
// ##########################################################
`timescale 1ns/1ps

module jtag_debug_top #(
    parameter int DMI_ADDR_BITS = 7,
    parameter int REG_DEPTH     = 16
) (
    input  logic jtag_tck_i,
    input  logic jtag_trst_ni,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic jtag_tdo_o
);

    import jtag_pkg::*;

    localparam int DMI_BITS = DMI_ADDR_BITS + DMI_DATA_BITS + DMI_OP_BITS;

    logic                tap_req;
    logic [DMI_BITS-1:0] tap_data;
    logic [DMI_BITS-1:0] dtm_resp;
    logic [31:0]         idcode;
    logic [31:0]         dtmcs;
    logic [DMI_BITS-1:0] dtm_req;
    logic                dtm_req_valid;
    logic                dmi_req_ready;
    logic [DMI_BITS-1:0] dmi_resp;
    logic                dmi_resp_valid;

    jtag_tap #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS)
    ) u_tap (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trst_ni (jtag_trst_ni),
        .tms_i        (jtag_tms_i),
        .tdi_i        (jtag_tdi_i),
        .tdo_o        (jtag_tdo_o),
        .tap_req_o    (tap_req),
        .tap_data_o   (tap_data),
        .dtm_resp_i   (dtm_resp),
        .idcode_i     (idcode),
        .dtmcs_i      (dtmcs)
    );

    jtag_dtm #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS)
    ) u_dtm (
        .jtag_tck_i       (jtag_tck_i),
        .jtag_trst_ni     (jtag_trst_ni),
        .tap_req_i        (tap_req),
        .tap_data_i       (tap_data),
        .data_o           (dtm_resp),
        .idcode_o         (idcode),
        .dtmcs_o          (dtmcs),
        .dtm_req_o        (dtm_req),
        .dtm_req_valid_o  (dtm_req_valid),
        .dmi_req_ready_i  (dmi_req_ready),
        .dmi_resp_i       (dmi_resp),
        .dmi_resp_valid_i (dmi_resp_valid)
    );

    jtag_dm_regs #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS),
        .REG_DEPTH     (REG_DEPTH)
    ) u_dm_regs (
        .jtag_tck_i       (jtag_tck_i),
        .jtag_trst_ni     (jtag_trst_ni),
        .dmi_req_i        (dtm_req),
        .dmi_req_valid_i  (dtm_req_valid),
        .dmi_req_ready_o  (dmi_req_ready),
        .dmi_resp_o       (dmi_resp),
        .dmi_resp_valid_o (dmi_resp_valid)
    );

endmodule

// ==== hw/jtag_dm_regs.sv ====
// ##########################################################
// debug module register file, answers DMI reads and writes
// ##########################################################
`timescale 1ns/1ps

module jtag_dm_regs #(
    parameter int DMI_ADDR_BITS = 7,
    parameter int REG_DEPTH     = 16,
    localparam int DMI_BITS = DMI_ADDR_BITS + jtag_pkg::DMI_DATA_BITS + jtag_pkg::DMI_OP_BITS
) (
    input  logic                jtag_tck_i,
    input  logic                jtag_trst_ni,
    input  logic [DMI_BITS-1:0] dmi_req_i,
    input  logic                dmi_req_valid_i,
    output logic                dmi_req_ready_o,
    output logic [DMI_BITS-1:0] dmi_resp_o,
    output logic                dmi_resp_valid_o
);

    import jtag_pkg::*;

    localparam int IDX_BITS = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

    logic [DMI_DATA_BITS-1:0] regs_q [REG_DEPTH];
    logic [DMI_BITS-1:0]      resp_q;
    logic                     resp_valid_q;
    logic [DMI_ADDR_BITS-1:0] req_addr;
    logic [DMI_DATA_BITS-1:0] req_data;
    logic [DMI_OP_BITS-1:0]   req_op;
    logic [IDX_BITS-1:0]      req_idx;
    logic                     in_range;
    logic                     req_fire;

    // request word is addr, data, op from msb down
    assign req_addr = dmi_req_i[DMI_BITS-1 -: DMI_ADDR_BITS];
    assign req_data = dmi_req_i[DMI_OP_BITS +: DMI_DATA_BITS];
    assign req_op   = dmi_req_i[DMI_OP_BITS-1:0];
    assign req_idx  = req_addr[IDX_BITS-1:0];
    assign in_range = int'(req_addr) < REG_DEPTH;

    assign dmi_req_ready_o = !resp_valid_q;      // stall while a response is out
    assign req_fire        = dmi_req_valid_i && dmi_req_ready_o;

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            resp_valid_q <= 1'b0;
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            resp_valid_q <= req_fire;
            if (req_fire && in_range && req_op == DMI_OP_WRITE) begin
                regs_q[req_idx] <= req_data;
            end
        end
    end

    always_ff @(posedge jtag_tck_i) begin
        if (req_fire) begin
            if (!in_range) begin
                resp_q <= {req_addr, {DMI_DATA_BITS{1'b0}}, DMI_RESP_FAILED};
            end else if (req_op == DMI_OP_WRITE) begin
                resp_q <= {req_addr, req_data, DMI_RESP_OK};    // echo the write
            end else begin
                resp_q <= {req_addr, regs_q[req_idx], DMI_RESP_OK};
            end
        end
    end

    assign dmi_resp_o       = resp_q;
    assign dmi_resp_valid_o = resp_valid_q;

    // one response per accepted request, carrying that request's address
    a_one_resp: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        req_fire |=> (dmi_resp_valid_o
                      && dmi_resp_o[DMI_BITS-1 -: DMI_ADDR_BITS] == $past(req_addr))
                     ##1 !dmi_resp_valid_o);

endmodule

// ==== hw/jtag_dtm.sv ====
// ##########################################################
// jtag DTM: sequences DMI reads and writes, reports busy
// and provides the IDCODE and DTMCS words
// ##########################################################
`timescale 1ns/1ps

module jtag_dtm #(
    parameter int DMI_ADDR_BITS = 7,
    localparam int DMI_BITS = DMI_ADDR_BITS + jtag_pkg::DMI_DATA_BITS + jtag_pkg::DMI_OP_BITS
) (
    input  logic                jtag_tck_i,
    input  logic                jtag_trst_ni,

    input  logic                tap_req_i,
    input  logic [DMI_BITS-1:0] tap_data_i,
    output logic [DMI_BITS-1:0] data_o,      // captured by the tap on dmi scans
    output logic [31:0]         idcode_o,
    output logic [31:0]         dtmcs_o,

    output logic [DMI_BITS-1:0] dtm_req_o,
    output logic                dtm_req_valid_o,
    input  logic                dmi_req_ready_i,
    input  logic [DMI_BITS-1:0] dmi_resp_i,
    input  logic                dmi_resp_valid_i
);

    import jtag_pkg::*;

    typedef enum logic [2:0] {
        DTM_IDLE,
        DTM_READ,
        DTM_WAIT_READ,
        DTM_WRITE,
        DTM_WAIT_WRITE
    } dtm_state_t;

    dtm_state_t state_q;
    dtm_state_t state_d;

    logic [DMI_BITS-1:0]    req_q;       // request held for the regs
    logic [DMI_BITS-1:0]    last_resp_q; // most recent dmi response
    logic [DMI_BITS-1:0]    resp_q;      // word shown to the tap
    logic                   busy_q;
    logic [DMI_OP_BITS-1:0] tap_op;
    logic [DMI_BITS-1:0]    busy_word;
    logic [1:0]             dmistat;

    assign tap_op    = tap_data_i[DMI_OP_BITS-1:0];
    assign busy_word = {{(DMI_BITS-DMI_OP_BITS){1'b0}}, DMI_RESP_BUSY};

    always_comb begin
        state_d = state_q;
        case (state_q)
            DTM_IDLE: begin
                if (tap_req_i && tap_op == DMI_OP_READ) begin
                    state_d = DTM_READ;
                end else if (tap_req_i && tap_op == DMI_OP_WRITE) begin
                    state_d = DTM_WRITE;
                end
            end
            DTM_READ:       if (dmi_req_ready_i)  state_d = DTM_WAIT_READ;
            DTM_WRITE:      if (dmi_req_ready_i)  state_d = DTM_WAIT_WRITE;
            DTM_WAIT_READ,
            DTM_WAIT_WRITE: if (dmi_resp_valid_i) state_d = DTM_IDLE;
            default:        state_d = DTM_IDLE;
        endcase
    end

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            state_q     <= DTM_IDLE;
            last_resp_q <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == DTM_WAIT_READ || state_q == DTM_WAIT_WRITE) && dmi_resp_valid_i) begin
                last_resp_q <= dmi_resp_i;
            end
        end
    end

    // request word, loaded only when a transaction starts
    always_ff @(posedge jtag_tck_i) begin
        if (state_q == DTM_IDLE && tap_req_i) begin
            req_q <= tap_data_i;
        end
    end

    // a transaction in flight shows busy one cycle later
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            resp_q <= '0;
            busy_q <= 1'b0;
        end else begin
            busy_q <= (state_q != DTM_IDLE);
            resp_q <= (state_q != DTM_IDLE) ? busy_word : last_resp_q;
        end
    end

    assign dtm_req_o       = req_q;
    assign dtm_req_valid_o = (state_q == DTM_READ) || (state_q == DTM_WRITE);
    assign data_o          = resp_q;

    assign dmistat  = busy_q ? 2'b11 : 2'b00;
    assign idcode_o = IDCODE_VALUE;
    assign dtmcs_o  = {14'b0,
                       1'b0,                 // dmihardreset
                       1'b0,                 // dmireset
                       1'b0,
                       3'd1,                 // idle hint
                       dmistat,
                       6'(DMI_ADDR_BITS),    // abits
                       DTM_VERSION};

    a_valid_stable: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        dtm_req_valid_o && !dmi_req_ready_i |=> dtm_req_valid_o && $stable(dtm_req_o));

    // the regs only answer requests this sequencer has handed over
    a_no_idle_resp: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        dmi_resp_valid_i |-> state_q inside {DTM_WAIT_READ, DTM_WAIT_WRITE});

endmodule

// ==== hw/jtag_pkg.sv ====
// ##########################################################
// jtag debug package: DMI widths, op codes, IR codes,
// identification word and TAP controller states
// ##########################################################

package jtag_pkg;

    // DMI word fields, the address width is a module parameter
    localparam int DMI_DATA_BITS = 32;
    localparam int DMI_OP_BITS   = 2;

    // request ops
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_NOP   = 2'd0;
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_READ  = 2'd1;
    localparam logic [DMI_OP_BITS-1:0] DMI_OP_WRITE = 2'd2;

    // response ops
    localparam logic [DMI_OP_BITS-1:0] DMI_RESP_OK     = 2'd0;
    localparam logic [DMI_OP_BITS-1:0] DMI_RESP_FAILED = 2'd2;
    localparam logic [DMI_OP_BITS-1:0] DMI_RESP_BUSY   = 2'd3;

    // instruction register
    localparam int IR_BITS = 5;
    localparam logic [IR_BITS-1:0] IR_IDCODE = 5'h01;
    localparam logic [IR_BITS-1:0] IR_DTMCS  = 5'h10;
    localparam logic [IR_BITS-1:0] IR_DMI    = 5'h11;
    localparam logic [IR_BITS-1:0] IR_BYPASS = 5'h1f;

    // id word: version, part number, manufacturer, fixed one
    localparam logic [3:0]  IDCODE_VERSION = 4'h1;
    localparam logic [15:0] IDCODE_PART    = 16'h0d41;
    localparam logic [10:0] IDCODE_MANUF   = 11'h0a5;
    localparam logic [31:0] IDCODE_VALUE   = {IDCODE_VERSION, IDCODE_PART, IDCODE_MANUF, 1'b1};

    localparam logic [3:0] DTM_VERSION = 4'h1; // debug spec 0.13

    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_t;

endpackage

// ==== hw/jtag_tap.sv ====
// ##########################################################
// jtag TAP: controller FSM, instruction register and
// shifting of the bypass, IDCODE, DTMCS and DMI registers
// ##########################################################
`timescale 1ns/1ps

module jtag_tap #(
    parameter int DMI_ADDR_BITS = 7,
    localparam int DMI_BITS = DMI_ADDR_BITS + jtag_pkg::DMI_DATA_BITS + jtag_pkg::DMI_OP_BITS
) (
    input  logic                jtag_tck_i,
    input  logic                jtag_trst_ni,
    input  logic                tms_i,
    input  logic                tdi_i,
    output logic                tdo_o,

    output logic                tap_req_o,   // one cycle in Update-DR
    output logic [DMI_BITS-1:0] tap_data_o,
    input  logic [DMI_BITS-1:0] dtm_resp_i,
    input  logic [31:0]         idcode_i,
    input  logic [31:0]         dtmcs_i
);

    import jtag_pkg::*;

    tap_state_t state_q;
    tap_state_t state_d;

    logic [IR_BITS-1:0]  ir_q;    // active instruction
    logic [IR_BITS-1:0]  ir_sr;   // instruction shift stage
    logic [DMI_BITS-1:0] dr_sr;   // shared data shift register

    // standard sixteen-state walk on tms
    always_comb begin
        state_d = state_q;
        case (state_q)
            TAP_RESET:      state_d = tms_i ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_d = tms_i ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_d = TAP_RESET;
        endcase
    end

    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            state_q <= TAP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // instruction path
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            ir_q  <= IR_IDCODE;
            ir_sr <= '0;
        end else begin
            case (state_q)
                TAP_RESET:      ir_q  <= IR_IDCODE;
                TAP_CAPTURE_IR: ir_sr <= 5'b00001;       // fixed capture pattern
                TAP_SHIFT_IR:   ir_sr <= {tdi_i, ir_sr[IR_BITS-1:1]};
                TAP_UPDATE_IR:  ir_q  <= ir_sr;
                default: ;
            endcase
        end
    end

    // data path, length follows the active instruction
    always_ff @(posedge jtag_tck_i or negedge jtag_trst_ni) begin
        if (!jtag_trst_ni) begin
            dr_sr <= '0;
        end else if (state_q == TAP_CAPTURE_DR) begin
            case (ir_q)
                IR_DMI:    dr_sr <= dtm_resp_i;
                IR_IDCODE: dr_sr <= DMI_BITS'(idcode_i);
                IR_DTMCS:  dr_sr <= DMI_BITS'(dtmcs_i);
                default:   dr_sr <= '0;                  // bypass captures 0
            endcase
        end else if (state_q == TAP_SHIFT_DR) begin
            case (ir_q)
                IR_DMI:              dr_sr <= {tdi_i, dr_sr[DMI_BITS-1:1]};
                IR_IDCODE, IR_DTMCS: dr_sr[31:0] <= {tdi_i, dr_sr[31:1]};
                default:             dr_sr[0] <= tdi_i;  // 1-bit bypass
            endcase
        end
    end

    assign tdo_o = (state_q == TAP_SHIFT_IR) ? ir_sr[0] : dr_sr[0];

    // dmi scans hand their word to the dtm, dtmcs writes go nowhere
    assign tap_req_o  = (state_q == TAP_UPDATE_DR) && (ir_q == IR_DMI);
    assign tap_data_o = dr_sr;

    // request only follows a finished dr shift, holds the shifted word, lasts one cycle
    a_req_in_update: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        tap_req_o |-> ($past(state_q) inside {TAP_EXIT1_DR, TAP_EXIT2_DR}
                       && $stable(tap_data_o)) ##1 !tap_req_o);

    a_state_known: assert property (@(posedge jtag_tck_i) disable iff (!jtag_trst_ni)
        !$isunknown(state_q));

endmodule

// ==== verification/tb_checker.sv ====
// ##########################################################
// testbench checker: compares scanned words, counts results
// ##########################################################
`timescale 1ns/1ps

module tb_checker (
    input logic jtag_tck_i,
    input logic jtag_trst_ni,
    input logic jtag_tdo_i
);

    string test_name    = "";
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    check_count  = 0;
    int    error_count  = 0;   // read by tb_top at the end

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic compare(input string what, input logic [63:0] got,
                           input logic [63:0] expected);
        check_count++;
        test_checks++;
        if (got !== expected) begin
            $display("CHECK FAILED at %0d ns: %s, %s got %h expected %h",
                     $time, test_name, what, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d checks, %0d errors)", test_name,
                 (test_errors == 0) ? "ok" : "FAIL", test_checks, test_errors);
    endtask

    task automatic print_counts();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
    endtask

    // tdo comes from registered state, never unknown out of reset
    always @(negedge jtag_tck_i) begin
        if (jtag_trst_ni && $isunknown(jtag_tdo_i)) begin
            $display("tdo is unknown at %0d ns in test %s", $time, test_name);
            error_count++;
            test_errors++;
        end
    end

endmodule

// ==== verification/tb_top.sv ====
// ##########################################################
// testbench for the jtag debug transport, scans over the TAP
// ##########################################################
`timescale 1ns/1ps

module tb_top;

    import jtag_pkg::*;

    localparam int DMI_ADDR_BITS   = 7;
    localparam int REG_DEPTH       = 16;
    localparam int DMI_BITS        = DMI_ADDR_BITS + DMI_DATA_BITS + DMI_OP_BITS;
    localparam int SCAN_CYCLES     = DMI_BITS + 12;            // longest scan plus state walk
    localparam longint WATCHDOG_NS = 2000 * SCAN_CYCLES * 40;

    logic jtag_tck;
    logic jtag_trst_n;
    logic jtag_tms;
    logic jtag_tdi;
    logic jtag_tdo;

    logic [DMI_DATA_BITS-1:0] model [REG_DEPTH];  // expected register contents
    logic [DMI_ADDR_BITS-1:0] addrs [6];

    jtag_debug_top #(
        .DMI_ADDR_BITS (DMI_ADDR_BITS),
        .REG_DEPTH     (REG_DEPTH)
    ) u_dut (
        .jtag_tck_i   (jtag_tck),
        .jtag_trst_ni (jtag_trst_n),
        .jtag_tms_i   (jtag_tms),
        .jtag_tdi_i   (jtag_tdi),
        .jtag_tdo_o   (jtag_tdo)
    );

    tb_checker u_checker (
        .jtag_tck_i   (jtag_tck),
        .jtag_trst_ni (jtag_trst_n),
        .jtag_tdo_i   (jtag_tdo)
    );

    always #20 jtag_tck = ~jtag_tck;

    // expected response for a read or write request
    function automatic logic [DMI_BITS-1:0] expected_resp(input logic [DMI_BITS-1:0] req);
        logic [DMI_ADDR_BITS-1:0] addr;
        logic [DMI_DATA_BITS-1:0] data;
        logic [DMI_OP_BITS-1:0]   op;
        addr = req[DMI_BITS-1 -: DMI_ADDR_BITS];
        data = req[DMI_OP_BITS +: DMI_DATA_BITS];
        op   = req[DMI_OP_BITS-1:0];
        if (int'(addr) >= REG_DEPTH) begin
            return {addr, {DMI_DATA_BITS{1'b0}}, DMI_RESP_FAILED};
        end
        if (op == DMI_OP_WRITE) begin
            model[addr] = data;
        end
        return {addr, model[addr], DMI_RESP_OK};
    endfunction

    // idle hint 1, dmistat, abits, version 1
    function automatic logic [31:0] expected_dtmcs(input logic [1:0] dmistat);
        return {17'b0, 3'd1, dmistat, 6'(DMI_ADDR_BITS), 4'd1};
    endfunction

    task automatic tck_cycle(input logic tms, input logic tdi);
        jtag_tms = tms;
        jtag_tdi = tdi;
        @(posedge jtag_tck);
        #2;
    endtask

    // lsb first, tdo sampled before the shifting edge
    task automatic shift_bits(input int len, input logic [63:0] din, output logic [63:0] dout);
        dout = '0;
        for (int i = 0; i < len; i++) begin
            dout[i] = jtag_tdo;
            tck_cycle(i == len - 1, din[i]);
        end
    endtask

    // idle to shift, shift, update, then leave update with leave_tms
    task automatic scan(input logic is_ir, input int len, input logic [63:0] din,
                        input logic leave_tms, output logic [63:0] dout);
        tck_cycle(1'b1, 1'b0);
        if (is_ir) tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);
        tck_cycle(1'b0, 1'b0);
        shift_bits(len, din, dout);
        tck_cycle(1'b1, 1'b0);
        tck_cycle(leave_tms, 1'b0);
    endtask

    task automatic dmi_scan(input logic [1:0] op, input logic [DMI_ADDR_BITS-1:0] addr,
                            input logic [31:0] data, input logic leave_tms,
                            output logic [DMI_BITS-1:0] word);
        logic [63:0] dout;
        scan(1'b0, DMI_BITS, 64'({addr, data, op}), leave_tms, dout);
        word = dout[DMI_BITS-1:0];
    endtask

    // request, idle for the transaction, then fetch with a nop
    task automatic dmi_access(input logic [1:0] op, input logic [DMI_ADDR_BITS-1:0] addr,
                              input logic [31:0] data, input string what);
        logic [DMI_BITS-1:0] word;
        logic [DMI_BITS-1:0] expected;
        expected = expected_resp({addr, data, op});
        dmi_scan(op, addr, data, 1'b0, word);
        repeat (4) tck_cycle(1'b0, 1'b0);
        dmi_scan(DMI_OP_NOP, '0, '0, 1'b0, word);
        u_checker.compare(what, word, expected);
    endtask

    initial begin
        logic [63:0]              dout;
        logic [DMI_BITS-1:0]      word;
        logic [DMI_BITS-1:0]      expected;
        logic [15:0]              pattern;
        logic [DMI_ADDR_BITS-1:0] addr;
        void'($urandom(83));
        jtag_tck    = 1'b0;
        jtag_trst_n = 1'b0;
        jtag_tms    = 1'b1;
        jtag_tdi    = 1'b0;
        foreach (model[i]) model[i] = '0;
        repeat (4) @(posedge jtag_tck);
        #2;
        jtag_trst_n = 1'b1;
        tck_cycle(1'b0, 1'b0);                 // into run-test/idle

        u_checker.begin_test("idcode after reset");
        scan(1'b0, 32, '0, 1'b0, dout);
        u_checker.compare("idcode", dout, IDCODE_VALUE);
        u_checker.end_test();

        u_checker.begin_test("bypass");
        scan(1'b1, IR_BITS, IR_BYPASS, 1'b0, dout);
        pattern = $urandom;
        scan(1'b0, 17, pattern, 1'b0, dout);
        u_checker.compare("one bit delay", dout, {pattern, 1'b0});
        u_checker.end_test();

        u_checker.begin_test("dtmcs fields");
        scan(1'b1, IR_BITS, IR_DTMCS, 1'b0, dout);
        scan(1'b0, 32, '0, 1'b0, dout);
        u_checker.compare("dtmcs", dout, expected_dtmcs(2'b00));
        u_checker.end_test();

        u_checker.begin_test("dmi write and read");
        scan(1'b1, IR_BITS, IR_DMI, 1'b0, dout);
        for (int i = 0; i < 6; i++) begin
            addrs[i] = $urandom_range(REG_DEPTH - 1);
            dmi_access(DMI_OP_WRITE, addrs[i], $urandom, "write");
        end
        for (int i = 0; i < 6; i++) begin
            dmi_access(DMI_OP_READ, addrs[i], '0, "read");
        end
        u_checker.end_test();

        u_checker.begin_test("address out of range");
        addr = REG_DEPTH + $urandom_range((1 << DMI_ADDR_BITS) - 1 - REG_DEPTH);
        dmi_access(DMI_OP_WRITE, addr, $urandom, "failed write");
        dmi_access(DMI_OP_READ, addr, '0, "failed read");
        dmi_access(DMI_OP_READ, addr % REG_DEPTH, '0, "aliased read");
        u_checker.end_test();

        u_checker.begin_test("busy response");
        addr     = addrs[$urandom_range(5)];
        expected = expected_resp({addr, 32'h0, DMI_OP_READ});
        dmi_scan(DMI_OP_READ, addr, '0, 1'b1, word);   // update straight to select-dr
        tck_cycle(1'b0, 1'b0);
        tck_cycle(1'b0, 1'b0);                         // capture edge inside the transaction
        u_checker.compare("dmistat", u_dut.dtmcs, expected_dtmcs(2'b11));
        shift_bits(DMI_BITS, '0, dout);
        tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);
        u_checker.compare("busy word", dout, {62'b0, DMI_RESP_BUSY});
        repeat (4) tck_cycle(1'b0, 1'b0);
        dmi_scan(DMI_OP_NOP, '0, '0, 1'b0, word);
        u_checker.compare("read after busy", word, expected);
        u_checker.end_test();

        u_checker.print_counts();
        if (u_checker.error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("the run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule
